//--- Makefile
# Verilator build for the cdc packet fifo testbench

VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = fifo_cdc_tb
FILELIST  = fifo_cdc.f
OBJ_DIR   = obj_dir
PASS_MSG  = TESTS PASSED

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# run from the project root so the data file path resolves
# exit status comes from grep, so a missing pass line fails the target
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/fifo_cdc_input.txt
# columns: W <packet hex, op[39:38] dest[37:32] data[31:0]> | S <stall cycles> | F | R | E
# each test runs until E; F fills all 16 entries, R randomizes ready_in
W 0100000001
W 4200000002
W 83deadbeef
W c4cafef00d
W 0512345678
W 469abcdef0
W 87ffffffff
W c800000000
W 0955aa55aa
W 4aaa55aa55
W 8b0f0f0f0f
W ccf0f0f0f0
E
S 40
W 0d11111111
W 4e22222222
W 8f33333333
W d044444444
W 1155555555
W 5266666666
W 9377777777
W d488888888
W 1599999999
W 56aaaaaaaa
W 97bbbbbbbb
W d8cccccccc
E
F
W 1900000010
W 5a00000011
W 9b00000012
W dc00000013
W 1d00000014
W 5e00000015
W 9f00000016
W e000000017
W 2100000018
W 6200000019
W a30000001a
W e40000001b
W 250000001c
W 660000001d
W a70000001e
W e80000001f
E
R
W 2901020304
W 6a05060708
W ab090a0b0c
W ec0d0e0f10
W 2d11121314
W 6e15161718
W af191a1b1c
W f01d1e1f20
W 3121222324
W 7225262728
W b3292a2b2c
W f42d2e2f30
W 3531323334
W 7635363738
W b7393a3b3c
W f83d3e3f40
W 3941424344
W 7a45464748
W bb494a4b4c
W fc4d4e4f50
E
R
W 3d13579bdf
W 7e2468ace0
W bf0badf00d
W c0feedface
W 0180808080
W 427f7f7f7f
W 8301010101
W c4fefefefe
E

//--- bench/fifo_cdc_tb.sv
// testbench for the cdc packet fifo with file-driven writer, random reader and scoreboard
`timescale 1ns/1ps
`include "fifo_cdc_cfg.svh"

module fifo_cdc_tb import fifo_cdc_pkg::*; ();

   localparam int M_STREAM = 0; // ready_in held high
   localparam int M_STALL  = 1; // ready_in low for stall_cnt cycles
   localparam int M_HOLD   = 2; // ready_in low until released
   localparam int M_RANDOM = 3; // ready_in from $urandom

   logic    nreset_out, clk_in, clk_out;
   logic    valid_in, ready_out, ready_in, valid_out;
   logic    prog_full, full, empty;
   packet_t packet_in, packet_out;

   packet_t exp_q[$];      // scoreboard in write order
   int      errors;        // failed checks overall
   int      tests_pass, tests_fail;
   int      rd_mode;       // reader behavior
   int      stall_cnt;     // remaining stall cycles
   int      stall_writes;  // writes accepted during a stall
   bit      pf_checked;    // ready_out drop seen in stall test
   int      cycles;        // clk_out cycle counter
   int      cycle_limit;   // 0 until the file is counted
   bit      last_stalled;  // previous edge had valid_out and no ready_in
   packet_t last_pkt;      // packet_out at previous edge

   fifo_cdc dut (
      .nreset_out (nreset_out),
      .clk_in     (clk_in),
      .valid_in   (valid_in),
      .packet_in  (packet_in),
      .ready_out  (ready_out),
      .clk_out    (clk_out),
      .ready_in   (ready_in),
      .valid_out  (valid_out),
      .packet_out (packet_out),
      .prog_full  (prog_full),
      .full       (full),
      .empty      (empty)
   );

   // ##########################################################
   // clocks with read at 20 ns and write at 14 ns
   // ##########################################################

   initial begin
      clk_out = 1'b0;
      forever #10 clk_out = ~clk_out;
   end

   initial begin
      clk_in = 1'b0;
      forever #7 clk_in = ~clk_in;
   end

   task automatic compare_value(input string name, input logic [39:0] exp,
                                input logic [39:0] got);
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic report_error(input string msg);
      errors++;
      $display("error at %0t: %s", $time, msg);
   endtask

   // ##########################################################
   // reader, scoreboard and timeout
   // ##########################################################

   always @(posedge clk_out) begin
      packet_t exp;
      if (cycles == 0) begin
         void'($urandom(63047)); // seed the reader's generator once
      end
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("run timed out after %0d clk_out cycles", cycles);
         $display("TESTS FAILED");
         $finish;
      end else if (nreset_out) begin
         // stalled packet must hold
         if (last_stalled && packet_out !== last_pkt) begin
            compare_value("packet_out", last_pkt, packet_out);
         end
         if (valid_out && ready_in) begin // consumed this edge
            if (exp_q.size() == 0) begin
               report_error("packet came out that was never written");
            end else begin
               exp = exp_q.pop_front();
               compare_value("packet_out", exp, packet_out);
            end
         end
         last_stalled = valid_out && !ready_in;
         last_pkt     = packet_out;
         #1;
         case (rd_mode)
            M_STALL: begin
               if (stall_cnt > 0) begin
                  ready_in = 1'b0;
                  stall_cnt--;
               end else begin
                  ready_in = 1'b1; // stall over
                  rd_mode  = M_STREAM;
               end
            end
            M_HOLD:   ready_in = 1'b0;
            M_RANDOM: ready_in = ($urandom % 2) != 0;
            default:  ready_in = 1'b1;
         endcase
      end
   end

   // ##########################################################
   // writer and test control
   // ##########################################################

   task automatic align_writer();
      @(posedge clk_in);
      #1; // writer acts 1 ns after clk_in
   endtask

   task automatic write_packet(input packet_t p, input bit obey);
      while (obey && !ready_out) begin
         align_writer();
      end
      if (rd_mode == M_STALL && stall_writes >= `CDC_PROG_FULL) begin
         report_error("more packets accepted than the programmable-full level");
      end
      valid_in  = 1'b1;
      packet_in = p;
      exp_q.push_back(p);
      if (rd_mode == M_STALL) stall_writes++;
      align_writer();
      valid_in = 1'b0;
      // prog_full registered at the edge of this write
      if (rd_mode == M_STALL && stall_writes == `CDC_PROG_FULL) begin
         compare_value("prog_full", 40'd1, {39'd0, prog_full});
         compare_value("ready_out", 40'd0, {39'd0, ready_out});
         pf_checked = 1'b1;
      end
   endtask

   task automatic drain_fifo();
      while (exp_q.size() != 0 || valid_out) @(posedge clk_out);
      repeat (6) @(posedge clk_out); // pointers settle both ways
      align_writer();
   endtask

   task automatic stall_reader(input int mode, input int n);
      drain_fifo();
      stall_writes = 0;
      pf_checked   = 1'b0;
      stall_cnt    = n;
      rd_mode      = mode;
      @(posedge clk_out);
      #2; // ready_in now low
      align_writer();
   endtask

   task automatic finish_test(input int num, input byte kind, inout int err_start);
      if (kind == "F") compare_value("full", 40'd1, {39'd0, full});
      if (kind == "S" && !pf_checked) begin
         report_error("ready_out was never checked at the programmable-full level");
      end
      rd_mode = M_STREAM;
      drain_fifo();
      if (kind == "F") begin
         compare_value("empty", 40'd1, {39'd0, empty});
         compare_value("valid_out", 40'd0, {39'd0, valid_out});
      end
      if (errors == err_start) begin
         tests_pass++;
         $display("test %0d (%c) passed", num, kind);
      end else begin
         tests_fail++;
         $display("test %0d (%c) failed", num, kind);
      end
      err_start = errors;
   endtask

   task automatic run_tests(input int fd);
      string      line;
      byte        cmd;
      byte        kind;
      logic [39:0] val;
      int         n;
      int         num;
      int         err_start;
      kind      = "T";
      num       = 1;
      err_start = errors;
      align_writer();
      while (!$feof(fd)) begin
         line = "";
         if ($fgets(line, fd) == 0) break;
         if (line.len() < 1) continue;
         cmd = line.getc(0);
         case (cmd)
            "W": begin
               if ($sscanf(line.substr(1, line.len() - 1), "%h", val) != 1) begin
                  report_error("write line without a packet value");
               end else begin
                  write_packet(packet_t'(val), kind != "F"); // F ignores pushback
               end
            end
            "S": begin
               if ($sscanf(line.substr(1, line.len() - 1), "%d", n) != 1) begin
                  report_error("stall line without a cycle count");
               end
               kind = "S";
               stall_reader(M_STALL, n);
            end
            "F": begin
               kind = "F";
               stall_reader(M_HOLD, 0);
            end
            "R": begin
               kind    = "R";
               rd_mode = M_RANDOM;
            end
            "E": begin
               finish_test(num, kind, err_start);
               num++;
               kind = "T";
            end
            default: ; // comment or blank line
         endcase
      end
   endtask

   initial begin
      int    fd;
      int    n_w;
      string line;
      nreset_out   = 1'b0;
      valid_in     = 1'b0;
      packet_in    = '0;
      ready_in     = 1'b0;
      errors       = 0;
      tests_pass   = 0;
      tests_fail   = 0;
      rd_mode      = M_STREAM;
      stall_cnt    = 0;
      stall_writes = 0;
      pf_checked   = 1'b0;
      cycles       = 0;
      cycle_limit  = 0;
      last_stalled = 1'b0;
      last_pkt     = '0;
      n_w          = 0;
      // count packet lines for the timeout
      fd = $fopen("bench/fifo_cdc_input.txt", "r");
      if (fd != 0) begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) == "W") n_w++;
         end
         $fclose(fd);
      end
      cycle_limit = 40 * n_w + 500;
      repeat (3) @(posedge clk_out);
      #1 nreset_out = 1'b1;
      repeat (4) @(posedge clk_out); // reset sync release
      #2;
      // reset values
      compare_value("valid_out", 40'd0, {39'd0, valid_out});
      compare_value("empty", 40'd1, {39'd0, empty});
      compare_value("full", 40'd0, {39'd0, full});
      compare_value("prog_full", 40'd0, {39'd0, prog_full});
      compare_value("ready_out", 40'd1, {39'd0, ready_out});
      if (errors == 0) begin
         tests_pass++;
         $display("test 0 (reset) passed");
      end else begin
         tests_fail++;
         $display("test 0 (reset) failed");
      end
      fd = $fopen("bench/fifo_cdc_input.txt", "r");
      if (fd == 0) begin
         report_error("could not open bench/fifo_cdc_input.txt");
      end else begin
         run_tests(fd);
         $fclose(fd);
      end
      $display("%0d tests passed, %0d tests failed, %0d check errors",
               tests_pass, tests_fail, errors);
      if (errors == 0 && tests_fail == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- fifo_cdc.f
+incdir+source
source/fifo_cdc_pkg.sv
source/reset_sync.sv
source/gray_ptr_sync.sv
source/fifo_async.sv
source/fifo_cdc.sv
bench/fifo_cdc_tb.sv

//--- source/fifo_async.sv
// dual-clock fifo with gray pointers, status flags and registered read port
`timescale 1ns/1ps
`include "fifo_cdc_cfg.svh"

module fifo_async import fifo_cdc_pkg::*; (
   // write side
   input  logic    wr_clk,    // write clock
   input  logic    wr_nreset, // write domain reset, active low
   input  logic    wr_en,     // push one entry
   input  packet_t din,       // write data
   // read side
   input  logic    rd_clk,    // read clock
   input  logic    rd_nreset, // read domain reset, active low
   input  logic    rd_en,     // pop one entry
   output packet_t dout,      // registered read data
   // status
   output logic    full,      // all entries used, write side
   output logic    prog_full, // fill level at threshold, write side
   output logic    empty      // nothing to read, read side
);

   localparam ptr_t PF_LEVEL = ptr_t'(`CDC_PROG_FULL); // threshold at pointer width

   // ##########################################################
   // gray code helpers
   // ##########################################################

   function automatic ptr_t bin2gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   function automatic ptr_t gray2bin(input ptr_t g);
      ptr_t b;
      b[`CDC_AW] = g[`CDC_AW]; // msb passes through
      for (int i = `CDC_AW - 1; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i]; // running xor from the top
      end
      return b;
   endfunction

   // ##########################################################
   // storage
   // ##########################################################

   packet_t mem [`CDC_DEPTH]; // no reset on the array

   ptr_t wr_bin;       // write pointer, binary
   ptr_t wr_gray;      // write pointer, gray, registered
   ptr_t wr_bin_next;
   ptr_t wr_gray_next;
   ptr_t rd_bin;       // read pointer, binary
   ptr_t rd_gray;      // read pointer, gray, registered
   ptr_t rd_bin_next;
   ptr_t rd_gray_next;
   ptr_t wr_gray_sync; // write pointer seen in rd_clk domain
   ptr_t rd_gray_sync; // read pointer seen in wr_clk domain
   ptr_t rd_bin_sync;  // synced read pointer back in binary
   ptr_t wr_level;     // fill level after this write

   // write port, address drops the wrap bit
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_bin[`CDC_AW-1:0]] <= din;
      end
   end

   // read port, loads only on a pop so dout holds under pushback
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         dout <= mem[rd_bin[`CDC_AW-1:0]];
      end
   end

   // ##########################################################
   // write domain
   // ##########################################################

   always_comb begin
      wr_bin_next  = wr_en ? wr_bin + ptr_t'(1) : wr_bin;
      wr_gray_next = bin2gray(wr_bin_next);
      rd_bin_sync  = gray2bin(rd_gray_sync);
      wr_level     = wr_bin_next - rd_bin_sync; // wraps correctly mod 2*depth
   end

   always_ff @(posedge wr_clk or negedge wr_nreset) begin
      if (!wr_nreset) begin
         wr_bin    <= '0;
         wr_gray   <= '0;
         full      <= 1'b0;
         prog_full <= 1'b0;
      end else begin
         wr_bin    <= wr_bin_next;
         wr_gray   <= wr_gray_next;
         // full when write is one lap ahead, top two gray bits flip
         full      <= (wr_gray_next == {~rd_gray_sync[`CDC_AW:`CDC_AW-1],
                                         rd_gray_sync[`CDC_AW-2:0]});
         prog_full <= (wr_level >= PF_LEVEL); // stale read ptr, conservative
      end
   end

   // read pointer into the write domain
   gray_ptr_sync u_rd2wr_sync (
      .clk     (wr_clk),
      .nreset  (wr_nreset),
      .ptr_in  (rd_gray),
      .ptr_out (rd_gray_sync)
   );

   // ##########################################################
   // read domain
   // ##########################################################

   always_comb begin
      rd_bin_next  = rd_en ? rd_bin + ptr_t'(1) : rd_bin;
      rd_gray_next = bin2gray(rd_bin_next);
   end

   always_ff @(posedge rd_clk or negedge rd_nreset) begin
      if (!rd_nreset) begin
         rd_bin  <= '0;
         rd_gray <= '0;
         empty   <= 1'b1; // nothing stored after reset
      end else begin
         rd_bin  <= rd_bin_next;
         rd_gray <= rd_gray_next;
         empty   <= (rd_gray_next == wr_gray_sync); // caught up with writer
      end
   end

   // write pointer into the read domain
   gray_ptr_sync u_wr2rd_sync (
      .clk     (rd_clk),
      .nreset  (rd_nreset),
      .ptr_in  (wr_gray),
      .ptr_out (wr_gray_sync)
   );

   // ##########################################################
   // checks
   // ##########################################################

   // writer upstream must honor the flags
   a_no_overflow : assert property (
      @(posedge wr_clk) disable iff (!wr_nreset) wr_en |-> !full
   ) else $error("fifo_async write while full");

   // top level must gate pops with empty
   a_no_underflow : assert property (
      @(posedge rd_clk) disable iff (!rd_nreset) rd_en |-> !empty
   ) else $error("fifo_async read while empty");

endmodule

//--- source/fifo_cdc.sv
// cdc packet fifo top with flow control, reset synchronizers and valid alignment
`timescale 1ns/1ps

module fifo_cdc import fifo_cdc_pkg::*; (
   input  logic    nreset_out, // async reset, active low
   // write side, clk_in domain
   input  logic    clk_in,     // write clock
   input  logic    valid_in,   // write strobe
   input  packet_t packet_in,  // write packet
   output logic    ready_out,  // write pushback, low means stop
   // read side, clk_out domain
   input  logic    clk_out,    // read clock
   input  logic    ready_in,   // read pushback from sink
   output logic    valid_out,  // read valid
   output packet_t packet_out, // read packet
   // status
   output logic    prog_full,  // threshold reached
   output logic    full,       // every entry used
   output logic    empty       // nothing buffered
);

   logic wr_nreset; // reset for clk_in logic
   logic rd_nreset; // reset for clk_out logic
   logic wr_en;
   logic rd_en;

   // ##########################################################
   // resets, one synchronizer per domain
   // ##########################################################

   reset_sync u_wr_rsync (
      .clk      (clk_in),
      .nrst_in  (nreset_out),
      .nrst_out (wr_nreset)
   );

   reset_sync u_rd_rsync (
      .clk      (clk_out),
      .nrst_in  (nreset_out),
      .nrst_out (rd_nreset)
   );

   // ##########################################################
   // flow control
   // ##########################################################

   assign wr_en     = valid_in;          // every strobe is a push
   assign rd_en     = ~empty & ready_in; // pop only when sink takes it
   assign ready_out = ~prog_full;        // early pushback leaves headroom

   fifo_async u_fifo (
      .wr_clk    (clk_in),
      .wr_nreset (wr_nreset),
      .wr_en     (wr_en),
      .din       (packet_in),
      .rd_clk    (clk_out),
      .rd_nreset (rd_nreset),
      .rd_en     (rd_en),
      .dout      (packet_out),
      .full      (full),
      .prog_full (prog_full),
      .empty     (empty)
   );

   // valid follows the registered read by one cycle
   // held while the sink stalls
   always_ff @(posedge clk_out or negedge rd_nreset) begin
      if (!rd_nreset) begin
         valid_out <= 1'b0;
      end else if (ready_in) begin
         valid_out <= rd_en;
      end
   end

   // a stalled packet must not change under the sink
   a_hold_on_stall : assert property (
      @(posedge clk_out) disable iff (!rd_nreset)
      (valid_out && !ready_in) |=> $stable(packet_out)
   ) else $error("fifo_cdc packet_out changed during stall");

endmodule

//--- source/fifo_cdc_cfg.svh
// fifo depth, address width and programmable-full threshold macros
`ifndef FIFO_CDC_CFG_SVH
`define FIFO_CDC_CFG_SVH

// ##########################################################
// fifo geometry
// ##########################################################

// number of entries, power of two
`define CDC_DEPTH 16

// address width, log2 of depth
`define CDC_AW 4

// ##########################################################
// flow control
// ##########################################################

// write-side fill level where ready_out drops
`define CDC_PROG_FULL 8

`endif

//--- source/fifo_cdc_pkg.sv
// packet opcode enum, packet struct and fifo pointer type
`include "fifo_cdc_cfg.svh"

package fifo_cdc_pkg;

   // packet opcode, carried opaque through the fifo
   typedef enum logic [1:0] {
      OP_WRITE  = 2'b00, // remote write
      OP_READ   = 2'b01, // remote read request
      OP_ATOMIC = 2'b10, // read-modify-write
      OP_CONFIG = 2'b11  // register access
   } pkt_op_t;

   // mesh packet, 40 bits, msb first
   typedef struct packed {
      pkt_op_t     op;   // [39:38]
      logic [5:0]  dest; // [37:32] mesh node id
      logic [31:0] data; // [31:0] payload
   } packet_t;

   // fifo pointer with wrap bit on top
   // wrap bit tells full from empty when the addresses match
   typedef logic [`CDC_AW:0] ptr_t;

endpackage

//--- source/gray_ptr_sync.sv
// two-flop synchronizer for a gray-coded fifo pointer
`timescale 1ns/1ps

module gray_ptr_sync import fifo_cdc_pkg::*; (
   input  logic clk,     // destination clock
   input  logic nreset,  // destination reset, active low
   input  ptr_t ptr_in,  // gray pointer from the source domain
   output ptr_t ptr_out  // gray pointer in the destination domain
);

   ptr_t meta_q; // first stage, may go metastable
   ptr_t sync_q; // second stage, settled

   // one bit changes per step, so a late sample
   // gives the old or the new pointer and nothing else
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= ptr_in;
         sync_q <= meta_q;
      end
   end

   assign ptr_out = sync_q;

endmodule

//--- source/reset_sync.sv
// reset synchronizer, async assert and sync release
`timescale 1ns/1ps

module reset_sync (
   input  logic clk,      // destination domain clock
   input  logic nrst_in,  // raw async reset, active low
   output logic nrst_out  // synchronized reset, active low
);

   logic [1:0] sync_q; // shift chain, fills with ones

   // clear at once, release two edges after nrst_in rises
   always_ff @(posedge clk or negedge nrst_in) begin
      if (!nrst_in) begin
         sync_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], 1'b1}; // shift a one in
      end
   end

   assign nrst_out = sync_q[1]; // last stage drives the domain

endmodule
